// File: sources.f
logic/snd_pkg.sv
logic/dma_strobe_sync.sv
logic/snd_bus_arbiter.sv
logic/snd_addr_decoder.sv
logic/snd_ram.sv
logic/snd_irq_sync.sv
logic/sound_bus_top.sv
verification/sound_bus_assertions.sv
verification/sound_bus_checker.sv
verification/tb_sound_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the sound bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_sound_bus -Mdir obj_dir

# The log decides the result, also when the simulator stops early
./obj_dir/Vtb_sound_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1

// File: verification/tb_sound_bus.sv
`timescale 1ns/1ps

module tb_sound_bus
    import snd_pkg::*;
();

    typedef enum {
        OP_CPU_WR, OP_CPU_RD, OP_DMA_WR, OP_DMA_RD, OP_DMA_REQ, OP_INT, OP_ACK, OP_NMI
    } op_e;

    typedef enum {PORT_BG, PORT_INT, PORT_NMI} port_e;

    typedef struct {
        string       name;
        op_e         op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp;
    } step_t;

    logic         mclk;
    logic         sndcpu_rst;
    snd_bus_req_t cpu_bus;
    logic         cpu_iorq_n;
    logic [7:0]   cpu_di;
    logic         cpu_int_n;
    logic         cpu_nmi_n;
    dma_port_t    dma;
    logic         dma_br;
    logic         dma_bg_n;
    logic [7:0]   dma_di;
    logic [7:0]   snd_code;
    logic         snd_int;
    logic         snd_nmi;

    step_t        steps[$];
    logic [7:0]   ref_mem [logic [13:0]];
    logic [31:0]  rnd;

    logic [15:0] ram_addrs [4] = '{16'h4000, 16'h5abc, 16'h6001, 16'h7ffe};
    logic [15:0] open_addrs [8] = '{16'h0123, 16'h2345, 16'h8000, 16'ha5a5,
                                    16'hc0de, 16'he000, 16'he003, 16'he007};
    logic [13:0] dma_words [2] = '{14'h0155, 14'h2aa0};

    always #5 mclk = ~mclk;

    sound_bus_top UUT (
        .i_mclk       (mclk),
        .i_sndcpu_rst (sndcpu_rst),
        .i_cpu_bus    (cpu_bus),
        .i_cpu_iorq_n (cpu_iorq_n),
        .o_cpu_di     (cpu_di),
        .o_cpu_int_n  (cpu_int_n),
        .o_cpu_nmi_n  (cpu_nmi_n),
        .i_dma        (dma),
        .i_dma_br     (dma_br),
        .o_dma_bg_n   (dma_bg_n),
        .o_dma_di     (dma_di),
        .i_snd_code   (snd_code),
        .i_snd_int    (snd_int),
        .i_snd_nmi    (snd_nmi)
    );

    sound_bus_checker chk (
        .i_cpu_di    (cpu_di),
        .i_dma_di    (dma_di),
        .i_dma_bg_n  (dma_bg_n),
        .i_cpu_int_n (cpu_int_n),
        .i_cpu_nmi_n (cpu_nmi_n)
    );

    ////////////////////////////////////////
    // Random data and the step table
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] next_byte();
        rnd = xorshift32(rnd);
        return rnd[7:0];
    endfunction

    function automatic void add_step(input string name, input op_e op, input logic [15:0] addr,
                                     input logic [7:0] data, input logic [7:0] exp);
        step_t s;
        s.name = name;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endfunction

    task automatic build_table();
        logic [7:0] d;
        foreach (ram_addrs[i]) begin
            d = next_byte();
            ref_mem[ram_addrs[i][13:0]] = d;
            add_step($sformatf("cpu_wr_%04h", ram_addrs[i]), OP_CPU_WR, ram_addrs[i], d, 8'h00);
        end
        // The read must see the newer byte of a second write
        d = next_byte();
        ref_mem[ram_addrs[1][13:0]] = d;
        add_step("cpu_overwrite", OP_CPU_WR, ram_addrs[1], d, 8'h00);
        foreach (ram_addrs[i]) begin
            add_step($sformatf("cpu_rd_%04h", ram_addrs[i]), OP_CPU_RD, ram_addrs[i], 8'h00,
                     ref_mem[ram_addrs[i][13:0]]);
        end
        add_step("snd_code_rd", OP_CPU_RD, 16'he001, 8'h00, snd_code);
        foreach (open_addrs[i]) begin
            add_step($sformatf("open_bus_%04h", open_addrs[i]), OP_CPU_RD, open_addrs[i],
                     8'h00, 8'hff);
        end
        add_step("dma_refused", OP_DMA_REQ, 16'h0000, 8'h01, 8'h01);
        add_step("cpu_wr_dmaen", OP_CPU_WR, 16'he002, next_byte(), 8'h00);
        add_step("dma_granted", OP_DMA_REQ, 16'h0000, 8'h01, 8'h00);
        foreach (dma_words[i]) begin
            d = next_byte();
            ref_mem[dma_words[i]] = d;
            add_step($sformatf("dma_wr_%04h", dma_words[i]), OP_DMA_WR, {2'b00, dma_words[i]},
                     d, 8'h00);
        end
        foreach (dma_words[i]) begin
            add_step($sformatf("dma_rd_%04h", dma_words[i]), OP_DMA_RD, {2'b00, dma_words[i]},
                     8'h00, ref_mem[dma_words[i]]);
        end
        add_step("dma_released", OP_DMA_REQ, 16'h0000, 8'h00, 8'h01);
        // DMA word w shows up at CPU address 0x4000 plus w
        foreach (dma_words[i]) begin
            add_step($sformatf("cpu_rd_dma_%04h", dma_words[i]), OP_CPU_RD,
                     16'h4000 + {2'b00, dma_words[i]}, 8'h00, ref_mem[dma_words[i]]);
        end
        add_step("int_held", OP_INT, 16'h0000, 8'h01, 8'h00);
        add_step("int_ack", OP_ACK, 16'h0000, 8'h00, 8'h01);
        add_step("nmi_on", OP_NMI, 16'h0000, 8'h01, 8'h00);
        add_step("nmi_off", OP_NMI, 16'h0000, 8'h00, 8'h01);
    endtask

    ////////////////////////////////////////
    // Waits on DUT outputs
    ////////////////////////////////////////
    function automatic logic port_bit(input port_e p);
        case (p)
            PORT_BG:  return dma_bg_n;
            PORT_INT: return cpu_int_n;
            default:  return cpu_nmi_n;
        endcase
    endfunction

    task automatic await_level(input string name, input port_e p, input logic lvl,
                               input int limit, output bit ok);
        int n;
        n = 0;
        while (port_bit(p) !== lvl && n < limit) begin
            @(negedge mclk);
            n++;
        end
        ok = (port_bit(p) === lvl);
        if (!ok) begin
            chk.record_failure(name, $sformatf("timed out after %0d cycles waiting for level %0b",
                                               limit, lvl));
        end
    endtask

    // Watch window that stops early when the level changes
    task automatic hold_level(input port_e p, input logic lvl, input int cycles);
        int n;
        n = 0;
        while (port_bit(p) === lvl && n < cycles) begin
            @(negedge mclk);
            n++;
        end
    endtask

    ////////////////////////////////////////
    // One table step
    ////////////////////////////////////////
    task automatic run_step(input step_t s);
        bit ok;
        case (s.op)
            OP_CPU_WR: begin
                cpu_bus.addr   = s.addr;
                cpu_bus.wdata  = s.data;
                cpu_bus.mreq_n = 1'b0;
                @(negedge mclk);
                cpu_bus.wr_n = 1'b0;
                @(negedge mclk);
                cpu_bus.wr_n = 1'b1;
                @(negedge mclk);
                cpu_bus.mreq_n = 1'b1;
                chk.record_done(s.name);
            end
            OP_CPU_RD: begin
                cpu_bus.addr   = s.addr;
                cpu_bus.mreq_n = 1'b0;
                cpu_bus.rd_n   = 1'b0;
                // Read data is registered one clock behind the address
                @(negedge mclk);
                chk.cpu_di_is(s.name, s.exp);
                cpu_bus.mreq_n = 1'b1;
                cpu_bus.rd_n   = 1'b1;
            end
            OP_DMA_WR, OP_DMA_RD: begin
                dma.addr      = s.addr[13:0];
                dma.wdata     = s.data;
                dma.rnw       = (s.op == OP_DMA_RD);
                dma.sndram_cs = 1'b1;
                @(negedge mclk);
                dma.lds_n = 1'b0;
                // Request comes 4 clocks after the strobe falls
                repeat (6) @(negedge mclk);
                dma.lds_n = 1'b1;
                repeat (6) @(negedge mclk);
                if (s.op == OP_DMA_RD) begin
                    chk.dma_di_is(s.name, s.exp);
                end else begin
                    chk.record_done(s.name);
                end
                dma.sndram_cs = 1'b0;
                dma.rnw       = 1'b1;
            end
            OP_DMA_REQ: begin
                dma_br = s.data[0];
                ok     = 1'b1;
                if (s.data[0] && s.exp[0]) begin
                    hold_level(PORT_BG, 1'b1, 20);
                end else begin
                    await_level(s.name, PORT_BG, s.exp[0], 16, ok);
                end
                if (ok) begin
                    chk.grant_is(s.name, s.exp[0]);
                end
            end
            OP_INT: begin
                snd_int = 1'b1;
                await_level(s.name, PORT_INT, 1'b0, 16, ok);
                if (ok) begin
                    // INT stays asserted until the acknowledge
                    hold_level(PORT_INT, 1'b0, 8);
                    chk.int_is(s.name, s.exp[0]);
                end
            end
            OP_ACK: begin
                // Input still high and only the acknowledge can release INT
                cpu_iorq_n = 1'b0;
                @(negedge mclk);
                cpu_iorq_n = 1'b1;
                await_level(s.name, PORT_INT, 1'b1, 16, ok);
                if (ok) begin
                    chk.int_is(s.name, s.exp[0]);
                end
                snd_int = 1'b0;
            end
            OP_NMI: begin
                snd_nmi = s.data[0];
                await_level(s.name, PORT_NMI, s.exp[0], 16, ok);
                if (ok) begin
                    chk.nmi_is(s.name, s.exp[0]);
                end
            end
            default: chk.record_failure(s.name, "unknown operation in the step table");
        endcase
    endtask

    initial begin
        mclk           = 1'b0;
        sndcpu_rst     = 1'b1;
        cpu_bus        = '0;
        cpu_bus.rd_n   = 1'b1;
        cpu_bus.wr_n   = 1'b1;
        cpu_bus.mreq_n = 1'b1;
        cpu_bus.rfsh_n = 1'b1;
        cpu_iorq_n     = 1'b1;
        dma            = '0;
        dma.rnw        = 1'b1;
        dma.lds_n      = 1'b1;
        dma_br         = 1'b0;
        snd_int        = 1'b0;
        snd_nmi        = 1'b0;
        rnd            = 32'h9bde_e6de;
        snd_code       = next_byte();
        build_table();

        repeat (3) @(negedge mclk);
        sndcpu_rst = 1'b0;
        @(negedge mclk);

        foreach (steps[i]) begin
            run_step(steps[i]);
            @(negedge mclk);
        end

        chk.print_counts();
        if (chk.err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verification/sound_bus_checker.sv
`timescale 1ns/1ps

module sound_bus_checker (
    input logic [7:0] i_cpu_di,
    input logic [7:0] i_dma_di,
    input logic       i_dma_bg_n,
    input logic       i_cpu_int_n,
    input logic       i_cpu_nmi_n
);

    int unsigned pass_count = 0;
    int unsigned err_count  = 0;

    ////////////////////////////////////////
    // Compare and log
    ////////////////////////////////////////
    task automatic judge(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act === exp) begin
            pass_count++;
            $display("PASS %s: 0x%02h", name, act);
        end else begin
            err_count++;
            $display("** Error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
        end
    endtask

    // Ports are read when the task is called
    task automatic cpu_di_is(input string name, input logic [7:0] exp);
        judge(name, exp, i_cpu_di);
    endtask

    task automatic dma_di_is(input string name, input logic [7:0] exp);
        judge(name, exp, i_dma_di);
    endtask

    task automatic grant_is(input string name, input logic exp);
        judge(name, {7'd0, exp}, {7'd0, i_dma_bg_n});
    endtask

    task automatic int_is(input string name, input logic exp);
        judge(name, {7'd0, exp}, {7'd0, i_cpu_int_n});
    endtask

    task automatic nmi_is(input string name, input logic exp);
        judge(name, {7'd0, exp}, {7'd0, i_cpu_nmi_n});
    endtask

    // Steps with nothing to read back
    task automatic record_done(input string name);
        pass_count++;
        $display("DONE %s", name);
    endtask

    task automatic record_failure(input string name, input string why);
        err_count++;
        $display("FAIL %s: %s", name, why);
    endtask

    task automatic print_counts();
        $display("Tests: %0d passed, %0d failed", pass_count, err_count);
    endtask

endmodule

// File: verification/sound_bus_assertions.sv
`timescale 1ns/1ps

module sound_bus_assertions (
    input logic i_mclk,
    input logic i_sndcpu_rst,
    input logic i_cpu_mreq_n,
    input logic i_dma_en,
    input logic i_dma_bg_n
);

    ////////////////////////////////////////
    // Grant rules
    ////////////////////////////////////////

    // Enable latch was set when the grant decision was made
    grant_needs_enable: assert property (
        @(posedge i_mclk) disable iff (i_sndcpu_rst)
        $fell(i_dma_bg_n) |-> $past(i_dma_en)
    ) else $error("DMA grant fell while the enable latch was clear");

    // No grant in the middle of a CPU memory cycle
    grant_between_cycles: assert property (
        @(posedge i_mclk) disable iff (i_sndcpu_rst)
        $fell(i_dma_bg_n) |-> $past(i_cpu_mreq_n)
    ) else $error("DMA grant fell while CPU mreq_n was low");

    grant_high_after_reset: assert property (
        @(posedge i_mclk) $fell(i_sndcpu_rst) |-> i_dma_bg_n
    ) else $error("DMA grant was low in the first cycle after reset");

endmodule

bind snd_bus_arbiter sound_bus_assertions u_assertions (
    .i_mclk       (i_mclk),
    .i_sndcpu_rst (i_sndcpu_rst),
    .i_cpu_mreq_n (i_cpu_bus.mreq_n),
    .i_dma_en     (dma_en),
    .i_dma_bg_n   (o_dma_bg_n)
);

// File: logic/sound_bus_top.sv
`timescale 1ns/1ps

module sound_bus_top
    import snd_pkg::*;
(
    input  logic                  i_mclk,
    input  logic                  i_sndcpu_rst,

    // Sound CPU side
    input  snd_bus_req_t          i_cpu_bus,
    input  logic                  i_cpu_iorq_n,
    output logic [SND_DATA_W-1:0] o_cpu_di,
    output logic                  o_cpu_int_n,
    output logic                  o_cpu_nmi_n,

    // Main CPU DMA side
    input  dma_port_t             i_dma,
    input  logic                  i_dma_br,
    output logic                  o_dma_bg_n,
    output logic [SND_DATA_W-1:0] o_dma_di,

    // From the main CPU latches
    input  logic [SND_DATA_W-1:0] i_snd_code,
    input  logic                  i_snd_int,
    input  logic                  i_snd_nmi
);

    snd_bus_req_t          bus;
    logic                  ram_wr;
    logic                  dmaen_wr;
    logic [SND_DATA_W-1:0] ram_q;
    logic [SND_DATA_W-1:0] rd_data;

    ////////////////////////////////////////
    // Bus ownership
    ////////////////////////////////////////
    snd_bus_arbiter u_arbiter (
        .i_mclk       (i_mclk),
        .i_sndcpu_rst (i_sndcpu_rst),
        .i_cpu_bus    (i_cpu_bus),
        .i_dma        (i_dma),
        .i_dma_br     (i_dma_br),
        .i_dmaen_wr   (dmaen_wr),
        .o_bus        (bus),
        .o_dma_bg_n   (o_dma_bg_n)
    );

    ////////////////////////////////////////
    // Decode and work RAM
    ////////////////////////////////////////
    snd_addr_decoder u_decoder (
        .i_mclk     (i_mclk),
        .i_bus      (bus),
        .i_ram_q    (ram_q),
        .i_snd_code (i_snd_code),
        .o_ram_cs   (),
        .o_ram_wr   (ram_wr),
        .o_dmaen_wr (dmaen_wr),
        .o_rd_data  (rd_data)
    );

    // RAM index is the low address bits of pages 2 and 3
    snd_ram u_ram (
        .i_mclk (i_mclk),
        .i_addr (bus.addr[RAM_AW-1:0]),
        .i_wr   (ram_wr),
        .i_din  (bus.wdata),
        .o_q    (ram_q)
    );

    // Both masters read the same data bus
    assign o_cpu_di = rd_data;
    assign o_dma_di = rd_data;

    ////////////////////////////////////////
    // Interrupts
    ////////////////////////////////////////
    snd_irq_sync u_irq_sync (
        .i_mclk       (i_mclk),
        .i_sndcpu_rst (i_sndcpu_rst),
        .i_snd_int    (i_snd_int),
        .i_snd_nmi    (i_snd_nmi),
        .i_cpu_iorq_n (i_cpu_iorq_n),
        .o_cpu_int_n  (o_cpu_int_n),
        .o_cpu_nmi_n  (o_cpu_nmi_n)
    );

endmodule

// File: logic/snd_irq_sync.sv
`timescale 1ns/1ps

module snd_irq_sync (
    input  logic i_mclk,
    input  logic i_sndcpu_rst,
    input  logic i_snd_int,
    input  logic i_snd_nmi,
    input  logic i_cpu_iorq_n,
    output logic o_cpu_int_n,
    output logic o_cpu_nmi_n
);

    logic [3:0] snd_int_sync;
    logic [1:0] snd_nmi_sync;

    ////////////////////////////////////////
    // INT, held until acknowledge
    ////////////////////////////////////////
    always_ff @(posedge i_mclk) begin
        if (i_sndcpu_rst) begin
            snd_int_sync <= 4'b0000;
        end else begin
            snd_int_sync <= {snd_int_sync[2:0], i_snd_int};
        end
    end

    // IORQ low is the acknowledge cycle
    always_ff @(posedge i_mclk) begin
        if (i_sndcpu_rst || !i_cpu_iorq_n) begin
            o_cpu_int_n <= 1'b1;
        end else if (snd_int_sync[3:2] == 2'b01) begin
            o_cpu_int_n <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // NMI level
    ////////////////////////////////////////
    always_ff @(posedge i_mclk) begin
        if (i_sndcpu_rst) begin
            snd_nmi_sync <= 2'b00;
        end else begin
            snd_nmi_sync <= {snd_nmi_sync[0], i_snd_nmi};
        end
    end

    assign o_cpu_nmi_n = ~snd_nmi_sync[1];

endmodule

// File: logic/snd_ram.sv
`timescale 1ns/1ps

module snd_ram
    import snd_pkg::*;
(
    input  logic                  i_mclk,
    input  logic [RAM_AW-1:0]     i_addr,
    input  logic                  i_wr,
    input  logic [SND_DATA_W-1:0] i_din,
    output logic [SND_DATA_W-1:0] o_q
);

    localparam int DEPTH = 2 ** RAM_AW;

    // 16K by 8 work RAM
    logic [SND_DATA_W-1:0] mem [DEPTH];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////
    always_ff @(posedge i_mclk) begin
        if (i_wr) begin
            mem[i_addr] <= i_din;
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // Old data during a write to the same word
    always_ff @(posedge i_mclk) begin
        o_q <= mem[i_addr];
    end

endmodule

// File: logic/snd_addr_decoder.sv
`timescale 1ns/1ps

module snd_addr_decoder
    import snd_pkg::*;
(
    input  logic                  i_mclk,
    input  snd_bus_req_t          i_bus,
    input  logic [SND_DATA_W-1:0] i_ram_q,
    input  logic [SND_DATA_W-1:0] i_snd_code,
    output logic                  o_ram_cs,
    output logic                  o_ram_wr,
    output logic                  o_dmaen_wr,
    output logic [SND_DATA_W-1:0] o_rd_data
);

    logic                  mem_acc;
    logic                  io_acc;
    logic                  sndcode_rd;
    logic                  rd_sel_ram;
    logic                  rd_sel_code;
    logic [SND_DATA_W-1:0] code_q;

    ////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////

    // Refresh cycles never select anything
    assign mem_acc = ~i_bus.mreq_n & i_bus.rfsh_n;

    always_comb begin
        o_ram_cs = 1'b0;
        if (mem_acc) begin
            case (i_bus.addr.pg.page)
                PAGE_RAM_LO: o_ram_cs = 1'b1;
                PAGE_RAM_HI: o_ram_cs = 1'b1;
                default:     o_ram_cs = 1'b0;
            endcase
        end
    end

    assign o_ram_wr = o_ram_cs & ~i_bus.wr_n;

    ////////////////////////////////////////
    // I/O page selects
    ////////////////////////////////////////
    assign io_acc = mem_acc && (i_bus.addr.io.page == PAGE_IO);

    always_comb begin
        sndcode_rd = 1'b0;
        o_dmaen_wr = 1'b0;
        if (io_acc) begin
            case (i_bus.addr.io.io_sel)
                IO_SNDCODE: sndcode_rd = 1'b1;
                IO_DMAEN:   o_dmaen_wr = 1'b1;
                default:    ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Read data
    ////////////////////////////////////////

    // Select and code byte line up with the RAM's registered output
    always_ff @(posedge i_mclk) begin
        rd_sel_ram  <= o_ram_cs;
        rd_sel_code <= sndcode_rd;
        code_q      <= i_snd_code;
    end

    // RAM first, then sound code, else open bus
    always_comb begin
        if (rd_sel_ram) begin
            o_rd_data = i_ram_q;
        end else if (rd_sel_code) begin
            o_rd_data = code_q;
        end else begin
            o_rd_data = OPEN_BUS;
        end
    end

endmodule

// File: logic/snd_bus_arbiter.sv
`timescale 1ns/1ps

module snd_bus_arbiter
    import snd_pkg::*;
(
    input  logic         i_mclk,
    input  logic         i_sndcpu_rst,
    input  snd_bus_req_t i_cpu_bus,
    input  dma_port_t    i_dma,
    input  logic         i_dma_br,
    input  logic         i_dmaen_wr,
    output snd_bus_req_t o_bus,
    output logic         o_dma_bg_n
);

    logic [1:0]   dma_br_sync;
    logic         dma_en;
    logic         dmaen_wr_z;
    logic         dma_wrrq_n;
    logic         dma_rdrq_n;
    snd_bus_req_t dma_bus;

    ////////////////////////////////////////
    // Request sync, enable latch, grant
    ////////////////////////////////////////
    always_ff @(posedge i_mclk) begin
        if (i_sndcpu_rst) begin
            dma_br_sync <= 2'b00;
            dmaen_wr_z  <= 1'b0;
            dma_en      <= 1'b0;
            o_dma_bg_n  <= 1'b1;
        end else begin
            dma_br_sync <= {dma_br_sync[0], i_dma_br};
            dmaen_wr_z  <= i_dmaen_wr;

            // Latch sets at the end of the enable write cycle
            if (dmaen_wr_z && !i_dmaen_wr) begin
                dma_en <= 1'b1;
            end

            // Grant only between CPU memory cycles
            if (o_dma_bg_n && dma_br_sync[1] && dma_en && i_cpu_bus.mreq_n) begin
                o_dma_bg_n <= 1'b0;
            end else if (!dma_br_sync[1]) begin
                o_dma_bg_n <= 1'b1;
            end
        end
    end

    // Strobes from the main CPU clock domain
    dma_strobe_sync u_strobe_sync (
        .i_mclk      (i_mclk),
        .i_dma_rnw   (i_dma.rnw),
        .i_dma_lds_n (i_dma.lds_n),
        .o_wrrq_n    (dma_wrrq_n),
        .o_rdrq_n    (dma_rdrq_n)
    );

    ////////////////////////////////////////
    // Bus owner mux
    ////////////////////////////////////////
    always_comb begin
        dma_bus.addr   = {DMA_PAGE_PREFIX, i_dma.addr};
        dma_bus.wdata  = i_dma.wdata;
        dma_bus.rd_n   = dma_rdrq_n;
        dma_bus.wr_n   = dma_wrrq_n;
        dma_bus.mreq_n = ~i_dma.sndram_cs;
        dma_bus.rfsh_n = 1'b1;
    end

    assign o_bus = o_dma_bg_n ? i_cpu_bus : dma_bus;

endmodule

// File: logic/dma_strobe_sync.sv
`timescale 1ns/1ps

module dma_strobe_sync (
    input  logic i_mclk,
    input  logic i_dma_rnw,
    input  logic i_dma_lds_n,
    output logic o_wrrq_n,
    output logic o_rdrq_n
);

    // Index 0 is the write strobe, index 1 the read strobe
    logic [1:0]      strobe_n;
    logic [1:0][3:0] strobe_sync;
    logic [1:0]      req_n;

    ////////////////////////////////////////
    // Raw strobes from the 68k bus
    ////////////////////////////////////////
    assign strobe_n[0] = i_dma_rnw | i_dma_lds_n;
    assign strobe_n[1] = ~i_dma_rnw | i_dma_lds_n;

    // Only the strobes cross here
    // address and data settle before the strobe drops
    always_ff @(posedge i_mclk) begin
        for (int i = 0; i < 2; i++) begin
            strobe_sync[i] <= {strobe_sync[i][2:0], strobe_n[i]};

            // Falling edge gives a one-cycle low request
            req_n[i] <= ~(strobe_sync[i][3] & ~strobe_sync[i][2]);
        end
    end

    ////////////////////////////////////////
    // Requests
    ////////////////////////////////////////
    assign o_wrrq_n = req_n[0];
    assign o_rdrq_n = req_n[1];

endmodule

// File: logic/snd_pkg.sv
package snd_pkg;

    ////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////
    localparam int SND_ADDR_W = 16;
    localparam int SND_DATA_W = 8;
    localparam int RAM_AW     = 14;
    localparam int DMA_AW     = 14;

    ////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////
    localparam logic [2:0] PAGE_RAM_LO = 3'd2;
    localparam logic [2:0] PAGE_RAM_HI = 3'd3;
    localparam logic [2:0] PAGE_IO     = 3'd7;

    // Selects inside the I/O page
    localparam logic [2:0] IO_SNDCODE = 3'd1;
    localparam logic [2:0] IO_DMAEN   = 3'd2;

    // DMA word address lands in the RAM pages
    localparam logic [1:0] DMA_PAGE_PREFIX = 2'b01;

    localparam logic [SND_DATA_W-1:0] OPEN_BUS = 8'hFF;

    ////////////////////////////////////////
    // Address views
    ////////////////////////////////////////
    typedef struct packed {
        logic [2:0]            page;
        logic [SND_ADDR_W-4:0] offset;
    } snd_page_view_t;

    typedef struct packed {
        logic [2:0]            page;
        logic [SND_ADDR_W-7:0] unused;
        logic [2:0]            io_sel;
    } snd_io_view_t;

    typedef union packed {
        snd_page_view_t pg;
        snd_io_view_t   io;
    } snd_addr_u;

    ////////////////////////////////////////
    // Bus cycle and DMA pins
    ////////////////////////////////////////
    typedef struct packed {
        snd_addr_u             addr;
        logic [SND_DATA_W-1:0] wdata;
        logic                  rd_n;
        logic                  wr_n;
        logic                  mreq_n;
        logic                  rfsh_n;
    } snd_bus_req_t;

    typedef struct packed {
        logic [DMA_AW-1:0]     addr;
        logic [SND_DATA_W-1:0] wdata;
        logic                  rnw;
        logic                  lds_n;
        logic                  sndram_cs;
    } dma_port_t;

endpackage
